// ==== design/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

  // posit format.
  localparam int N  = 16;
  localparam int ES = 1;

  // signed total exponent as delivered by the normalizer.
  localparam int TE_BITS = 8;

  // the regime value k is clamped to +/-(N-2) and always fits here.
  localparam int K_BITS = 6;

  localparam int FRAC_FULL_SIZE = 16;  // fraction without hidden bit.
  localparam int MANT_SIZE      = N - 3;

  localparam int REG_LEN_BITS  = 5;  // regime run plus terminator, up to N bits.
  localparam int MANT_LEN_BITS = 6;  // signed, the fraction field can be negative.

  // the shift between full and kept fraction is held in S+2 bits.
  localparam int S = 5;

  // special encodings.
  localparam logic [N-1:0] MAXPOS = {1'b0, {(N - 1) {1'b1}}};
  localparam logic [N-1:0] MINPOS = {{(N - 1) {1'b0}}, 1'b1};
  localparam logic [N-1:0] NAR    = {1'b1, {(N - 1) {1'b0}}};

  function automatic int min(input int a, input int b);
    if (a < b) begin
      return a;
    end
    return b;
  endfunction

  function automatic int max(input int a, input int b);
    if (a > b) begin
      return a;
    end
    return b;
  endfunction

endpackage

`default_nettype wire

// ==== design/ppu_stream_pkg.sv ====
`default_nettype none

package ppu_stream_pkg;
  import ppu_pkg::*;

  // normalized value waiting to be encoded.
  typedef struct packed {
    logic                      sign;
    logic                      is_zero;
    logic                      is_nar;
    logic [TE_BITS-1:0]        total_exp;
    logic [FRAC_FULL_SIZE-1:0] frac_full;
    logic                      frac_truncated;
  } enc_in_t;

  // encoded result.
  typedef struct packed {
    logic [N-1:0] posit;
  } enc_out_t;

endpackage

`default_nettype wire

// ==== design/pack_fields.sv ====
`timescale 1ns/1ps
`default_nettype none

module pack_fields
  import ppu_pkg::*;
(
  input  wire  [TE_BITS-1:0]        total_exp_i,
  input  wire  [FRAC_FULL_SIZE-1:0] frac_full_i,

  output logic [K_BITS-1:0]         k_o,
  output logic [ES-1:0]             next_exp_o,
  output logic [MANT_SIZE-1:0]      frac_o,
  output logic [MANT_LEN_BITS-1:0]  frac_len_o,
  output logic [S+1:0]              frac_len_diff_o,
  output logic                      k_is_oob_o,
  output logic                      non_zero_frac_field_size_o
);

  logic signed [TE_BITS-1:0]       k_raw;
  logic signed [TE_BITS-1:0]       k_clamped;
  logic        [ES-1:0]            exp_raw;
  logic        [REG_LEN_BITS-1:0]  reg_len;
  logic signed [MANT_LEN_BITS-1:0] frac_len;
  int                              es_len;
  int                              exp_drop;

  // total_exp = k * 2^ES + exp.
  assign k_raw   = $signed(total_exp_i) >>> ES;
  assign exp_raw = total_exp_i[ES-1:0];

  // beyond +/-(N-2) the regime alone no longer fits into the word.
  assign k_clamped  = TE_BITS'(max(min(int'(k_raw), N - 2), 2 - N));
  assign k_is_oob_o = k_raw != k_clamped;
  assign k_o        = K_BITS'(k_clamped);

  // run of k+1 ones or -k zeros, plus the terminating bit.
  assign reg_len = k_clamped[TE_BITS-1] ? REG_LEN_BITS'(1 - k_clamped)
                                        : REG_LEN_BITS'(k_clamped + 2);

  assign frac_len = MANT_LEN_BITS'(N - 1 - ES - int'(reg_len));

  // exponent bits left in the word after sign and regime, may go negative.
  assign es_len = min(ES, N - 1 - int'(reg_len));

  // the exponent keeps its bits down to the first position below the word.
  // that bit is the round bit when the fraction field has no room at all.
  // anything deeper is zeroed.
  assign exp_drop   = max(0, ES - es_len - 1);
  assign next_exp_o = (exp_raw >> exp_drop) << exp_drop;

  assign frac_len_diff_o = (S + 2)'(FRAC_FULL_SIZE - int'(frac_len));

  // leading frac_len bits of the fraction, right aligned.
  assign frac_o = MANT_SIZE'(frac_full_i >> frac_len_diff_o);

  assign frac_len_o                 = frac_len;
  assign non_zero_frac_field_size_o = !frac_len[MANT_LEN_BITS-1];

endmodule

`default_nettype wire

// ==== design/compute_rounding.sv ====
`timescale 1ns/1ps
`default_nettype none

module compute_rounding
  import ppu_pkg::*;
(
  input  wire [FRAC_FULL_SIZE-1:0] frac_full_i,
  input  wire [MANT_LEN_BITS-1:0]  frac_len_i,
  input  wire [S+1:0]              frac_len_diff_i,
  input  wire                      frac_truncated_i,

  output logic                     round_bit_o,
  output logic                     sticky_bit_o
);

  logic                      field_neg;
  logic [FRAC_FULL_SIZE-1:0] round_mask;
  logic [FRAC_FULL_SIZE-1:0] sticky_mask;

  assign field_neg = frac_len_i[MANT_LEN_BITS-1];

  // one-hot on the first fraction bit that does not fit.
  // with a negative field the round position lies in the exponent instead.
  always_comb begin
    if (field_neg) begin
      round_mask = '0;
    end else begin
      round_mask = FRAC_FULL_SIZE'(1) << (frac_len_diff_i - 1'b1);
    end
  end

  // everything below the round bit.
  always_comb begin
    if (field_neg) begin
      sticky_mask = '1;  // the whole fraction is pushed out.
    end else begin
      sticky_mask = round_mask - 1'b1;
    end
  end

  assign round_bit_o = |(frac_full_i & round_mask);

  // bits already lost upstream count as sticky.
  assign sticky_bit_o = (|(frac_full_i & sticky_mask)) | frac_truncated_i;

endmodule

`default_nettype wire

// ==== design/posit_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_assembler
  import ppu_pkg::*;
(
  input  wire                 sign_i,
  input  wire                 is_zero_i,
  input  wire                 is_nar_i,
  input  wire [K_BITS-1:0]    k_i,
  input  wire [ES-1:0]        next_exp_i,
  input  wire [MANT_SIZE-1:0] frac_i,
  input  wire                 k_is_oob_i,
  input  wire                 non_zero_frac_field_size_i,
  input  wire                 round_bit_i,
  input  wire                 sticky_bit_i,

  output logic [N-1:0]        posit_o
);

  logic signed [K_BITS-1:0]       k;
  logic        [REG_LEN_BITS-1:0] reg_len;
  logic        [REG_LEN_BITS-1:0] run_len;
  logic        [N-1:0]            regime_u;
  logic        [N-1:0]            exp_u;
  logic        [N-1:0]            frac_u;
  logic        [N-1:0]            word_u;
  logic        [N-2:0]            mag;
  logic        [N-2:0]            mag_round;
  logic        [N-2:0]            mag_clamped;
  logic        [N-2:0]            mag_final;
  logic                           guard_bit;
  logic                           round_up;
  logic        [N-1:0]            signed_word;

  assign k       = $signed(k_i);
  assign reg_len = k[K_BITS-1] ? REG_LEN_BITS'(1 - k) : REG_LEN_BITS'(k + 2);
  assign run_len = reg_len - 1'b1;

  // word_u is the magnitude (N-1 bits) followed by one extra bit at the
  // round position, so an exponent that is pushed out still lands there.
  always_comb begin
    if (k[K_BITS-1]) begin
      regime_u = {1'b1, {(N - 1) {1'b0}}} >> run_len;  // zeros, then a one.
    end else begin
      regime_u = ~({N{1'b1}} >> run_len);  // ones, then a zero.
    end
  end

  assign exp_u  = {next_exp_i, {(N - ES) {1'b0}}} >> reg_len;
  assign frac_u = {{(N - MANT_SIZE - 1) {1'b0}}, frac_i, 1'b0};
  assign word_u = regime_u | exp_u | frac_u;

  assign mag = word_u[N-1:1];

  assign guard_bit = non_zero_frac_field_size_i ? round_bit_i : word_u[0];
  assign round_up  = guard_bit & (sticky_bit_i | mag[0]);  // nearest, ties to even.

  // maxpos never rounds up into NaR.
  assign mag_round = (round_up && mag != MAXPOS[N-2:0]) ? mag + 1'b1 : mag;

  assign mag_clamped = (mag_round < MINPOS[N-2:0]) ? MINPOS[N-2:0] : mag_round;

  always_comb begin
    if (k_is_oob_i) begin
      mag_final = k[K_BITS-1] ? MINPOS[N-2:0] : MAXPOS[N-2:0];
    end else begin
      mag_final = mag_clamped;
    end
  end

  assign signed_word = sign_i ? ~{1'b0, mag_final} + 1'b1 : {1'b0, mag_final};

  always_comb begin
    if (is_nar_i) begin
      posit_o = NAR;
    end else if (is_zero_i) begin
      posit_o = '0;
    end else begin
      posit_o = signed_word;
    end
  end

endmodule

`default_nettype wire

// ==== design/pipe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
  parameter type T = logic
) (
  input  wire   clk_i,
  input  wire   rst_i,

  input  wire   valid_i,
  output logic  ready_o,
  input  wire T data_i,

  output logic  valid_o,
  input  wire   ready_i,
  output T      data_o
);

  // the slot can take new data when it is empty or drains this cycle.
  assign ready_o = !valid_o || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_o <= data_i;  // loads only on a transfer.
    end
  end

endmodule

`default_nettype wire

// ==== design/posit_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_encoder
  import ppu_pkg::*;
  import ppu_stream_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,

  input  wire                      in_valid_i,
  output logic                     in_ready_o,
  input  wire                      sign_i,
  input  wire                      is_zero_i,
  input  wire                      is_nar_i,
  input  wire [TE_BITS-1:0]        total_exp_i,
  input  wire [FRAC_FULL_SIZE-1:0] frac_full_i,
  input  wire                      frac_truncated_i,

  output logic [N-1:0]             posit_o,
  output logic                     out_valid_o,
  input  wire                      out_ready_i
);

  enc_in_t                  in_data;
  enc_in_t                  in_q;
  logic                     in_q_valid;
  logic                     in_q_ready;

  logic [K_BITS-1:0]        k;
  logic [ES-1:0]            next_exp;
  logic [MANT_SIZE-1:0]     frac;
  logic [MANT_LEN_BITS-1:0] frac_len;
  logic [S+1:0]             frac_len_diff;
  logic                     k_is_oob;
  logic                     non_zero_frac_field_size;
  logic                     round_bit;
  logic                     sticky_bit;
  logic [N-1:0]             posit_word;

  enc_out_t                 out_data;
  enc_out_t                 out_q;

  assign in_data = '{
    sign:           sign_i,
    is_zero:        is_zero_i,
    is_nar:         is_nar_i,
    total_exp:      total_exp_i,
    frac_full:      frac_full_i,
    frac_truncated: frac_truncated_i
  };

  pipe_stage #(
    .T       (enc_in_t)
  ) in_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_data),
    .valid_o (in_q_valid),
    .ready_i (in_q_ready),
    .data_o  (in_q)
  );

  pack_fields pack_fields_inst (
    .total_exp_i                (in_q.total_exp),
    .frac_full_i                (in_q.frac_full),
    .k_o                        (k),
    .next_exp_o                 (next_exp),
    .frac_o                     (frac),
    .frac_len_o                 (frac_len),
    .frac_len_diff_o            (frac_len_diff),
    .k_is_oob_o                 (k_is_oob),
    .non_zero_frac_field_size_o (non_zero_frac_field_size)
  );

  compute_rounding compute_rounding_inst (
    .frac_full_i      (in_q.frac_full),
    .frac_len_i       (frac_len),
    .frac_len_diff_i  (frac_len_diff),
    .frac_truncated_i (in_q.frac_truncated),
    .round_bit_o      (round_bit),
    .sticky_bit_o     (sticky_bit)
  );

  posit_assembler posit_assembler_inst (
    .sign_i                     (in_q.sign),
    .is_zero_i                  (in_q.is_zero),
    .is_nar_i                   (in_q.is_nar),
    .k_i                        (k),
    .next_exp_i                 (next_exp),
    .frac_i                     (frac),
    .k_is_oob_i                 (k_is_oob),
    .non_zero_frac_field_size_i (non_zero_frac_field_size),
    .round_bit_i                (round_bit),
    .sticky_bit_i               (sticky_bit),
    .posit_o                    (posit_word)
  );

  assign out_data = '{posit: posit_word};

  pipe_stage #(
    .T       (enc_out_t)
  ) out_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (in_q_valid),
    .ready_o (in_q_ready),
    .data_i  (out_data),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_q)
  );

  assign posit_o = out_q.posit;

endmodule

`default_nettype wire

// ==== test/posit_encoder_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_encoder_checker
  import ppu_pkg::*;
(
  input wire         clk_i,
  input wire         rst_i,
  input wire         in_valid_i,
  input wire         in_ready_o,
  input wire         is_nar_i,
  input wire [N-1:0] posit_o,
  input wire         out_valid_o,
  input wire         out_ready_i
);

  int nar_pending;  // NaR inputs accepted but not yet sent out.
  int assert_failures = 0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      nar_pending <= 0;
    end else begin
      nar_pending <= nar_pending + int'(in_valid_i && in_ready_o && is_nar_i)
                     - int'(out_valid_o && out_ready_i && posit_o == NAR);
    end
  end

  reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else begin
      $error("out_valid_o is high in the cycle after reset.");
      assert_failures++;
    end

  out_held: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(posit_o))
    else begin
      $error("output valid or data changed while out_ready_i was low.");
      assert_failures++;
    end

  nar_only_from_nar: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && posit_o == NAR |-> nar_pending > 0)
    else begin
      $error("NaR on the output without a NaR input in flight.");
      assert_failures++;
    end

endmodule

bind posit_encoder posit_encoder_checker checker_inst (.*);

`default_nettype wire

// ==== test/posit_encoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_encoder_tb
  import ppu_pkg::*;
();

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_TESTS    = 2000;
  localparam logic [31:0] SEED         = 32'h1305_f270;

  logic                      clk_i, rst_i, in_valid_i, in_ready_o;
  logic                      sign_i, is_zero_i, is_nar_i, frac_truncated_i;
  logic [TE_BITS-1:0]        total_exp_i;
  logic [FRAC_FULL_SIZE-1:0] frac_full_i;
  logic [N-1:0]              posit_o;
  logic                      out_valid_o, out_ready_i;

  logic [N-1:0] expected_q[$];
  string        name_q[$];
  int           accept_q[$];
  logic [N-1:0] expected;
  string        name;
  string        test_name;
  int           accepted_at;
  int           sent = 0;
  int           received = 0;
  int           cycle = 0;
  int           last_stall = -1;
  int           value_errors = 0;
  int           latency_errors = 0;
  int           protocol_errors = 0;
  logic         launched;

  posit_encoder DUT (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .sign_i           (sign_i),
    .is_zero_i        (is_zero_i),
    .is_nar_i         (is_nar_i),
    .total_exp_i      (total_exp_i),
    .frac_full_i      (frac_full_i),
    .frac_truncated_i (frac_truncated_i),
    .posit_o          (posit_o),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // fraction bits left after sign, regime run, terminator and exponent.
  function automatic int frac_field_len(input int k);
    int reg_len;
    reg_len = (k < 0) ? 1 - k : k + 2;
    return N - 1 - ES - reg_len;
  endfunction

  // writes the unbounded bit string, cuts it to N-1 bits and rounds to nearest even.
  function automatic logic [N-1:0] model_posit(input logic sign, input logic zero,
      input logic nar, input logic [TE_BITS-1:0] te, input logic [FRAC_FULL_SIZE-1:0] frac,
      input logic trunc);
    logic [63:0]  bits;
    logic [N-2:0] mag;
    logic [N-1:0] word;
    logic         guard;
    logic         sticky;
    int           k;
    int           pos;
    if (nar) return NAR;
    if (zero) return '0;
    k = int'($signed(te)) >>> ES;
    if (k > N - 2) begin
      mag = MAXPOS[N-2:0];
    end else if (k < 2 - N) begin
      mag = MINPOS[N-2:0];
    end else begin
      bits = '0;
      pos  = 63;
      for (int i = 0; i < ((k < 0) ? -k : k + 1); i++) begin
        bits[pos] = (k >= 0);
        pos--;
      end
      bits[pos] = (k < 0);  // terminator.
      pos--;
      for (int i = ES - 1; i >= 0; i--) begin
        bits[pos] = te[i];
        pos--;
      end
      for (int i = FRAC_FULL_SIZE - 1; i >= 0; i--) begin
        bits[pos] = frac[i];
        pos--;
      end
      mag    = bits[63 -: N - 1];
      guard  = bits[64 - N];
      sticky = (|(bits << N)) || trunc;
      if (guard && (sticky || mag[0]) && mag != MAXPOS[N-2:0]) mag = mag + 1'b1;
      if (mag == '0) mag = MINPOS[N-2:0];  // never rounds to zero.
    end
    word = {1'b0, mag};
    return sign ? -word : word;
  endfunction

  task automatic make_item();
    int                        mode;
    int                        te;
    int                        len;
    logic [FRAC_FULL_SIZE-1:0] keep;
    mode             = $urandom % 16;
    sign_i           = $urandom;
    is_zero_i        = 1'b0;
    is_nar_i         = 1'b0;
    frac_full_i      = $urandom;
    frac_truncated_i = $urandom;
    te               = int'($urandom % 50) - 24;  // k from -12 to 12 keeps the exponent.
    len              = frac_field_len(te >>> ES);
    keep             = ~({FRAC_FULL_SIZE{1'b1}} >> len);
    if (mode < 4) begin
      test_name        = "exact";
      frac_full_i      = frac_full_i & keep;
      frac_truncated_i = 1'b0;
    end else if (mode < 8) begin
      // round bit set and all bits below it clear.
      frac_full_i = (frac_full_i & keep) | (FRAC_FULL_SIZE'(1) << (FRAC_FULL_SIZE - 1 - len));
      test_name   = frac_truncated_i ? "round_sticky" : "tie";
    end else if (mode < 12) begin
      test_name = "random";
      te        = int'($urandom % 62) - 30;
    end else if (mode < 14) begin
      test_name = "saturate";
      te        = ($urandom % 2) ? 30 + int'($urandom % 98) : -29 - int'($urandom % 100);
    end else begin
      test_name = (mode == 14) ? "zero" : "nar";
      is_zero_i = (mode == 14);
      is_nar_i  = (mode == 15);
      te        = int'($urandom % 256) - 128;
    end
    total_exp_i = TE_BITS'(te);
  endtask

  task automatic print_counts();
    $display("errors: value %0d, latency %0d, protocol %0d, assertion %0d",
             value_errors, latency_errors, protocol_errors,
             DUT.checker_inst.assert_failures);
  endtask

  // outputs are popped before new inputs are pushed.
  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycle++;
      if (!out_ready_i) last_stall = cycle;
      if (out_valid_o && out_ready_i) begin
        if (expected_q.size() == 0) begin
          $display("ERROR: output %h arrived with no accepted input pending", posit_o);
          protocol_errors++;
        end else begin
          expected    = expected_q.pop_front();
          name        = name_q.pop_front();
          accepted_at = accept_q.pop_front();
          assert (posit_o == expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, posit_o);
            value_errors++;
          end
          if (last_stall < accepted_at) begin  // out_ready_i stayed high all along.
            assert (cycle - accepted_at == 2) else begin
              $display("CHECK FAILED latency %s: expected 2, actual %0d", name,
                       cycle - accepted_at);
              latency_errors++;
            end
          end
          received++;
        end
      end
      if (in_valid_i && in_ready_o) begin
        expected_q.push_back(model_posit(sign_i, is_zero_i, is_nar_i, total_exp_i,
                                         frac_full_i, frac_truncated_i));
        name_q.push_back(test_name);
        accept_q.push_back(cycle);
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    in_valid_i       = 1'b0;
    sign_i           = 1'b0;
    is_zero_i        = 1'b0;
    is_nar_i         = 1'b0;
    total_exp_i      = '0;
    frac_full_i      = '0;
    frac_truncated_i = 1'b0;
    out_ready_i      = 1'b1;
    test_name        = "idle";
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 rst_i = 1'b0;
    while (received < NUM_TESTS) begin
      @(posedge clk_i);
      launched = in_valid_i && in_ready_o;
      #1;
      if (!in_valid_i || launched) begin
        in_valid_i = 1'b0;
        if (sent < NUM_TESTS && ($urandom % 4) != 0) begin
          make_item();
          in_valid_i = 1'b1;
          sent++;
        end
      end
      // the first quarter runs without back-pressure.
      out_ready_i = (sent < NUM_TESTS / 4) ? 1'b1 : (($urandom % 4) != 0);
    end
    repeat (4) @(posedge clk_i);
    if (expected_q.size() != 0) begin
      $display("ERROR: %0d accepted inputs never came out", expected_q.size());
      protocol_errors++;
    end
    print_counts();
    if (value_errors + latency_errors + protocol_errors
        + DUT.checker_inst.assert_failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // twenty cycles per test is far more than the worst stall pattern needs.
  initial begin
    #(NUM_TESTS * 20 * CLK_PERIOD);
    $display("ERROR: timeout, only %0d of %0d outputs arrived", received, NUM_TESTS);
    print_counts();
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/ppu_pkg.sv
design/ppu_stream_pkg.sv
design/pack_fields.sv
design/compute_rounding.sv
design/posit_assembler.sv
design/pipe_stage.sv
design/posit_encoder.sv
test/posit_encoder_checker.sv
test/posit_encoder_tb.sv
